// File: hdl/cache_wt_pkg.sv
// ===================================================================
// front-end and back-end widths of the write-through path
// write request and aligned beat structs
// ===================================================================
`default_nettype none

package cache_wt_pkg;

   localparam int ADDR_W      = 32;              // byte address
   localparam int FE_DATA_W   = 32;              // front-end word
   localparam int FE_NBYTES   = FE_DATA_W / 8;
   localparam int FE_NBYTES_W = $clog2(FE_NBYTES);
   localparam int WORD_ADDR_W = ADDR_W - FE_NBYTES_W;

   localparam int BE_DATA_W   = 64;              // back-end beat
   localparam int BE_NBYTES   = BE_DATA_W / 8;
   localparam int BE_NBYTES_W = $clog2(BE_NBYTES);
   localparam int LANES       = BE_DATA_W / FE_DATA_W;

   // one accepted front-end write
   typedef struct packed {
      logic [WORD_ADDR_W-1:0] addr;              // word address
      logic [FE_DATA_W-1:0]   data;
      logic [FE_NBYTES-1:0]   strb;
   } wr_req_t;

   // one beat placed in its back-end lane
   typedef struct packed {
      logic [ADDR_W-1:0]    addr;                // beat aligned byte address
      logic [BE_DATA_W-1:0] data;
      logic [BE_NBYTES-1:0] strb;
   } be_beat_t;

endpackage

`default_nettype wire

// File: hdl/axi_wr_pkg.sv
// ===================================================================
// AXI4 write channel field widths, response and burst codes
// aw, w and b channel structs
// ===================================================================
`default_nettype none

package axi_wr_pkg;

   localparam int ID_W    = 4;
   localparam int LEN_W   = 8;
   localparam int SIZE_W  = 3;
   localparam int BURST_W = 2;
   localparam int CACHE_W = 4;
   localparam int QOS_W   = 4;
   localparam int RESP_W  = 2;

   localparam logic [RESP_W-1:0]  RESP_OKAY   = 2'b00;
   localparam logic [RESP_W-1:0]  RESP_SLVERR = 2'b10;
   localparam logic [BURST_W-1:0] BURST_FIXED = 2'b00;

   // address phase
   typedef struct packed {
      logic [ID_W-1:0]                 id;
      logic [cache_wt_pkg::ADDR_W-1:0] addr;
      logic [LEN_W-1:0]                len;
      logic [SIZE_W-1:0]               size;
      logic [BURST_W-1:0]              burst;
      logic                            lock;
      logic [CACHE_W-1:0]              cache;
      logic [QOS_W-1:0]                qos;
   } axi_aw_t;

   // data phase
   typedef struct packed {
      logic [cache_wt_pkg::BE_DATA_W-1:0] data;
      logic [cache_wt_pkg::BE_NBYTES-1:0] strb;
      logic                               last;
   } axi_w_t;

   // response phase
   typedef struct packed {
      logic [ID_W-1:0]   id;
      logic [RESP_W-1:0] resp;
   } axi_b_t;

endpackage

`default_nettype wire

// File: hdl/wt_write_buffer.sv
// ===================================================================
// circular FIFO of accepted write requests
// ===================================================================
`timescale 1ns/1ps
`default_nettype none

module wt_write_buffer #(
   parameter int BUFFER_DEPTH_W = 2              // log2 of entry count
) (
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  push_i,
   input  cache_wt_pkg::wr_req_t req_i,
   output logic                  full_o,
   output logic                  not_empty_o,
   output cache_wt_pkg::wr_req_t head_o,
   input  logic                  pop_i
);

   localparam int DEPTH = 2 ** BUFFER_DEPTH_W;

   cache_wt_pkg::wr_req_t mem [DEPTH];

   logic [BUFFER_DEPTH_W-1:0] wr_ptr;
   logic [BUFFER_DEPTH_W-1:0] rd_ptr;
   logic [BUFFER_DEPTH_W:0]   count;            // one extra bit for full
   logic                      do_push;
   logic                      do_pop;

   assign do_push = push_i & ~full_o;
   assign do_pop  = pop_i & not_empty_o;

   assign full_o      = (count == DEPTH[BUFFER_DEPTH_W:0]);
   assign not_empty_o = (count != '0);
   assign head_o      = mem[rd_ptr];

   // pointers and occupancy
   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;             // wraps at DEPTH
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;             // both or neither
         endcase
      end
   end

   // storage
   always_ff @(posedge clk_i) begin
      if (do_push) begin
         mem[wr_ptr] <= req_i;
      end
   end

endmodule

`default_nettype wire

// File: hdl/wt_lane_align.sv
// ===================================================================
// register stage placing a front-end word into its back-end lane
// ===================================================================
`timescale 1ns/1ps
`default_nettype none

module wt_lane_align (
   input  logic                   clk_i,
   input  logic                   reset_i,
   input  cache_wt_pkg::wr_req_t  head_i,
   input  logic                   not_empty_i,
   output logic                   pop_o,
   output cache_wt_pkg::be_beat_t beat_o,
   output logic                   beat_valid_o,
   input  logic                   beat_take_i
);

   localparam int LANE_W = $clog2(cache_wt_pkg::LANES);

   cache_wt_pkg::be_beat_t beat_d;
   cache_wt_pkg::be_beat_t beat_q;
   logic                   full_q;
   logic                   load;
   logic [LANE_W-1:0]      lane;

   // reload when empty or when the channel takes the current beat
   assign load  = not_empty_i & (~full_q | beat_take_i);
   assign pop_o = load;
   assign lane  = head_i.addr[LANE_W-1:0];      // byte address bit 2

   always_comb begin
      beat_d.addr = {head_i.addr[cache_wt_pkg::WORD_ADDR_W-1:LANE_W],
                     {cache_wt_pkg::BE_NBYTES_W{1'b0}}};
      beat_d.data = {cache_wt_pkg::LANES{head_i.data}};  // same word in every lane
      beat_d.strb = cache_wt_pkg::BE_NBYTES'(head_i.strb) << (lane * cache_wt_pkg::FE_NBYTES);
   end

   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         full_q <= 1'b0;
      end else if (load) begin
         full_q <= 1'b1;
      end else if (beat_take_i) begin
         full_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (load) begin
         beat_q <= beat_d;
      end
   end

   assign beat_o       = beat_q;
   assign beat_valid_o = full_q;

endmodule

`default_nettype wire

// File: hdl/axi_write_channel.sv
// ===================================================================
// single-beat AXI4 write channel FSM
// address, data and response phases with retry on error response
// ===================================================================
`timescale 1ns/1ps
`default_nettype none

module axi_write_channel #(
   parameter logic [axi_wr_pkg::ID_W-1:0] AXI_ID = 1
) (
   input  logic                   clk_i,
   input  logic                   reset_i,

   // aligned beats from the lane stage
   input  cache_wt_pkg::be_beat_t beat_i,
   input  logic                   beat_valid_i,
   output logic                   beat_take_o,

   // AXI write address
   output axi_wr_pkg::axi_aw_t    axi_aw_o,
   output logic                   axi_awvalid_o,
   input  logic                   axi_awready_i,

   // AXI write data
   output axi_wr_pkg::axi_w_t     axi_w_o,
   output logic                   axi_wvalid_o,
   input  logic                   axi_wready_i,

   // AXI write response
   input  axi_wr_pkg::axi_b_t     axi_b_i,
   input  logic                   axi_bvalid_i,
   output logic                   axi_bready_o
);

   typedef enum logic [1:0] {
      ST_IDLE   = 2'd0,
      ST_ADDR   = 2'd1,
      ST_WRITE  = 2'd2,
      ST_VERIFY = 2'd3
   } state_t;

   state_t                 state_q;
   state_t                 state_d;
   cache_wt_pkg::be_beat_t beat_q;
   logic                   resp_ok;

   assign resp_ok     = (axi_b_i.resp == axi_wr_pkg::RESP_OKAY);
   assign beat_take_o = (state_q == ST_IDLE) & beat_valid_i;

   // next state
   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (beat_valid_i) begin
               state_d = ST_ADDR;
            end
         end
         ST_ADDR: begin
            if (axi_awready_i) begin
               state_d = ST_WRITE;
            end
         end
         ST_WRITE: begin
            if (axi_wready_i) begin
               state_d = ST_VERIFY;
            end
         end
         default: begin
            // an error response sends the same beat out again
            if (axi_bvalid_i) begin
               state_d = resp_ok ? ST_IDLE : ST_ADDR;
            end
         end
      endcase
   end

   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // held for every retry of this beat
   always_ff @(posedge clk_i) begin
      if (beat_take_o) begin
         beat_q <= beat_i;
      end
   end

   assign axi_awvalid_o = (state_q == ST_ADDR);
   assign axi_wvalid_o  = (state_q == ST_WRITE);
   assign axi_bready_o  = (state_q == ST_VERIFY);

   always_comb begin
      axi_aw_o.id    = AXI_ID;
      axi_aw_o.addr  = beat_q.addr;
      axi_aw_o.len   = '0;                       // single beat
      axi_aw_o.size  = axi_wr_pkg::SIZE_W'(cache_wt_pkg::BE_NBYTES_W);
      axi_aw_o.burst = axi_wr_pkg::BURST_FIXED;
      axi_aw_o.lock  = 1'b0;                     // normal access
      axi_aw_o.cache = 4'b0011;                  // bufferable, modifiable
      axi_aw_o.qos   = '0;
   end

   always_comb begin
      axi_w_o.data = beat_q.data;
      axi_w_o.strb = beat_q.strb;
      axi_w_o.last = axi_wvalid_o;               // every beat is the last
   end

endmodule

`default_nettype wire

// File: hdl/cache_write_path.sv
// ===================================================================
// write-through cache write path toward AXI4 memory
// ===================================================================
`timescale 1ns/1ps
`default_nettype none

module cache_write_path #(
   parameter int                          BUFFER_DEPTH_W = 2,
   parameter logic [axi_wr_pkg::ID_W-1:0] AXI_ID         = 1
) (
   input  logic                  clk_i,
   input  logic                  reset_i,

   // front end
   input  logic                  valid_i,
   input  cache_wt_pkg::wr_req_t req_i,
   output logic                  ready_o,

   // AXI write master
   output axi_wr_pkg::axi_aw_t   axi_aw_o,
   output logic                  axi_awvalid_o,
   input  logic                  axi_awready_i,
   output axi_wr_pkg::axi_w_t    axi_w_o,
   output logic                  axi_wvalid_o,
   input  logic                  axi_wready_i,
   input  axi_wr_pkg::axi_b_t    axi_b_i,
   input  logic                  axi_bvalid_i,
   output logic                  axi_bready_o
);

   cache_wt_pkg::wr_req_t  head;
   cache_wt_pkg::be_beat_t beat;
   logic                   full;
   logic                   not_empty;
   logic                   pop;
   logic                   beat_valid;
   logic                   beat_take;

   assign ready_o = ~full;

   wt_write_buffer #(
      .BUFFER_DEPTH_W(BUFFER_DEPTH_W)
   ) u_buffer (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .push_i      (valid_i & ready_o),
      .req_i       (req_i),
      .full_o      (full),
      .not_empty_o (not_empty),
      .head_o      (head),
      .pop_i       (pop)
   );

   wt_lane_align u_align (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .head_i       (head),
      .not_empty_i  (not_empty),
      .pop_o        (pop),
      .beat_o       (beat),
      .beat_valid_o (beat_valid),
      .beat_take_i  (beat_take)
   );

   axi_write_channel #(
      .AXI_ID(AXI_ID)
   ) u_channel (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .beat_i        (beat),
      .beat_valid_i  (beat_valid),
      .beat_take_o   (beat_take),
      .axi_aw_o      (axi_aw_o),
      .axi_awvalid_o (axi_awvalid_o),
      .axi_awready_i (axi_awready_i),
      .axi_w_o       (axi_w_o),
      .axi_wvalid_o  (axi_wvalid_o),
      .axi_wready_i  (axi_wready_i),
      .axi_b_i       (axi_b_i),
      .axi_bvalid_i  (axi_bvalid_i),
      .axi_bready_o  (axi_bready_o)
   );

endmodule

`default_nettype wire

// File: sim/axi_mem_model.sv
// ===================================================================
// AXI4 write slave model with byte memory and handshake log
// stall inputs per channel, SLVERR injection on a chosen response
// ===================================================================
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model (
   input  logic                clk_i,
   input  logic                reset_i,
   input  axi_wr_pkg::axi_aw_t aw_i,
   input  logic                awvalid_i,
   output logic                awready_o,
   input  axi_wr_pkg::axi_w_t  w_i,
   input  logic                wvalid_i,
   output logic                wready_o,
   output axi_wr_pkg::axi_b_t  b_o,
   output logic                bvalid_o,
   input  logic                bready_i,
   input  logic                stall_aw_i,
   input  logic                stall_w_i,
   input  int                  err_at_i          // response number given SLVERR, 0 for none
);

   localparam int MEM_BYTES = 256;

   logic [7:0]  mem    [MEM_BYTES];
   logic [31:0] aw_log [MEM_BYTES];               // aw addresses in handshake order
   int          aw_count;
   int          b_count;
   int          ok_count;
   logic [31:0] addr_q;
   logic [63:0] w_last_data;

   assign awready_o = ~stall_aw_i;
   assign wready_o  = ~stall_w_i;

   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         for (int i = 0; i < MEM_BYTES; i++) begin
            mem[i] <= 8'h00;
         end
         aw_count    <= 0;
         b_count     <= 0;
         ok_count    <= 0;
         bvalid_o    <= 1'b0;
         b_o         <= '0;
         addr_q      <= '0;
         w_last_data <= '0;
      end else begin
         if (awvalid_i && awready_o) begin
            aw_log[aw_count[7:0]] <= aw_i.addr;
            aw_count              <= aw_count + 1;
            addr_q                <= aw_i.addr;
            b_o.id                <= aw_i.id;
         end
         if (wvalid_i && wready_o) begin
            w_last_data <= w_i.data;
            bvalid_o    <= 1'b1;
            if (b_count + 1 == err_at_i) begin
               b_o.resp <= axi_wr_pkg::RESP_SLVERR;   // memory left untouched
            end else begin
               b_o.resp <= axi_wr_pkg::RESP_OKAY;
               for (int j = 0; j < 8; j++) begin
                  if (w_i.strb[j]) begin
                     mem[addr_q[7:0] + j] <= w_i.data[8*j +: 8];
                  end
               end
            end
         end
         if (bvalid_o && bready_i) begin
            bvalid_o <= 1'b0;
            b_count  <= b_count + 1;
            if (b_o.resp == axi_wr_pkg::RESP_OKAY) begin
               ok_count <= ok_count + 1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: sim/cache_write_path_properties.sv
// ===================================================================
// AXI write protocol assertions, bound to the write channel
// ===================================================================
`timescale 1ns/1ps
`default_nettype none

module cache_write_path_properties (
   input  logic                clk_i,
   input  logic                reset_i,
   input  axi_wr_pkg::axi_aw_t aw_i,
   input  logic                awvalid_i,
   input  logic                awready_i,
   input  axi_wr_pkg::axi_w_t  w_i,
   input  logic                wvalid_i,
   input  logic                wready_i,
   input  logic                bready_i
);

   // valid held with stable fields until ready
   aw_stable: assert property (@(posedge clk_i) disable iff (reset_i)
      awvalid_i && !awready_i |=> awvalid_i && $stable(aw_i))
      else $error("awvalid dropped or aw fields changed before awready");

   w_stable: assert property (@(posedge clk_i) disable iff (reset_i)
      wvalid_i && !wready_i |=> wvalid_i && $stable(w_i))
      else $error("wvalid dropped or w fields changed before wready");

   wlast_match: assert property (@(posedge clk_i) disable iff (reset_i)
      w_i.last == wvalid_i)
      else $error("wlast differs from wvalid");

   len_zero: assert property (@(posedge clk_i) disable iff (reset_i)
      awvalid_i |-> aw_i.len == '0)
      else $error("awlen is not zero");

   idle_in_reset: assert property (@(posedge clk_i)
      reset_i |-> !awvalid_i && !wvalid_i && !bready_i)
      else $error("AXI valid or ready high during reset");

endmodule

bind axi_write_channel cache_write_path_properties u_props (
   .clk_i     (clk_i),
   .reset_i   (reset_i),
   .aw_i      (axi_aw_o),
   .awvalid_i (axi_awvalid_o),
   .awready_i (axi_awready_i),
   .w_i       (axi_w_o),
   .wvalid_i  (axi_wvalid_o),
   .wready_i  (axi_wready_i),
   .bready_i  (axi_bready_o)
);

`default_nettype wire

// File: sim/tb_cache_write_path.sv
// ===================================================================
// directed tests of the write-through write path
// reference byte memory, random stalls, error retry, final report
// ===================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_cache_write_path;

   localparam logic [31:0] SEED    = 32'd61842;
   localparam int          TIMEOUT = 2000;        // cycles per wait

   logic                  clk_i;
   logic                  reset_i;
   logic                  valid_i;
   cache_wt_pkg::wr_req_t req_i;
   logic                  ready_o;
   axi_wr_pkg::axi_aw_t   axi_aw;
   axi_wr_pkg::axi_w_t    axi_w;
   axi_wr_pkg::axi_b_t    axi_b;
   logic                  awvalid, awready, wvalid, wready, bvalid, bready;
   logic                  stall_aw, stall_w;
   int                    err_at;
   int                    stall_mode;             // 0 none, 1 random, 2 aw held
   logic [31:0]           rng_state;
   logic [31:0]           stall_rng;
   logic [7:0]            ref_mem [256];
   logic [31:0]           exp_aw[$];
   int                    aw_base;
   int                    sent;
   int                    errors;

   cache_write_path #(.BUFFER_DEPTH_W(2), .AXI_ID(1)) u_cache_write_path (
      .clk_i(clk_i), .reset_i(reset_i), .valid_i(valid_i), .req_i(req_i), .ready_o(ready_o),
      .axi_aw_o(axi_aw), .axi_awvalid_o(awvalid), .axi_awready_i(awready),
      .axi_w_o(axi_w), .axi_wvalid_o(wvalid), .axi_wready_i(wready),
      .axi_b_i(axi_b), .axi_bvalid_i(bvalid), .axi_bready_o(bready)
   );

   axi_mem_model u_mem (
      .clk_i(clk_i), .reset_i(reset_i), .aw_i(axi_aw), .awvalid_i(awvalid), .awready_o(awready),
      .w_i(axi_w), .wvalid_i(wvalid), .wready_o(wready), .b_o(axi_b), .bvalid_o(bvalid),
      .bready_i(bready), .stall_aw_i(stall_aw), .stall_w_i(stall_w), .err_at_i(err_at)
   );

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift(rng_state);
      return rng_state;
   endfunction

   // slave stall pattern, updated 1 ns after each edge
   initial begin
      stall_aw  = 1'b0;
      stall_w   = 1'b0;
      stall_rng = xorshift(SEED);
      forever begin
         @(posedge clk_i);
         #1;
         stall_rng = xorshift(stall_rng);
         stall_aw  = (stall_mode == 2) || (stall_mode == 1 && stall_rng[1:0] != 2'b00);
         stall_w   = (stall_mode == 1) && stall_rng[3:2] == 2'b00;
      end
   end

   function automatic void apply_ref(input logic [31:0] addr, input logic [31:0] data,
                                     input logic [3:0] strb);
      for (int j = 0; j < 4; j++) begin
         if (strb[j]) begin
            ref_mem[{addr[7:2], 2'b00} + j] = data[8*j +: 8];
         end
      end
   endfunction

   task automatic send_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
      int cycles;
      cycles     = 0;
      valid_i    = 1'b1;
      req_i.addr = addr[31:2];
      req_i.data = data;
      req_i.strb = strb;
      while (!ready_o && cycles < TIMEOUT) begin
         @(posedge clk_i);
         #1;
         cycles++;
      end
      assert (ready_o) else begin
         errors++;
         $display("write to %h was never accepted, ready_o stayed low", addr);
      end
      if (ready_o) begin
         @(posedge clk_i);                        // taken on this edge
         #1;
         apply_ref(addr, data, strb);
         exp_aw.push_back({addr[31:3], 3'b000});
         sent++;
      end
      valid_i = 1'b0;
   endtask

   task automatic wait_drained();
      int cycles;
      cycles = 0;
      while (u_mem.ok_count != sent && cycles < TIMEOUT) begin
         @(posedge clk_i);
         #1;
         cycles++;
      end
      assert (u_mem.ok_count == sent) else begin
         errors++;
         $display("timed out waiting for %0d writes to get an OKAY response", sent);
      end
   endtask

   // fixed address-phase fields, sampled while awvalid is high
   task automatic check_aw_fields();
      int cycles;
      cycles = 0;
      while (!awvalid && cycles < TIMEOUT) begin
         @(posedge clk_i);
         #1;
         cycles++;
      end
      assert (awvalid) else begin
         errors++;
         $display("awvalid never rose, address-phase fields not checked");
      end
      assert ({axi_aw.id, axi_aw.len, axi_aw.size, axi_aw.burst, axi_aw.lock, axi_aw.cache,
               axi_aw.qos} === {4'h1, 8'h00, 3'd3, 2'b00, 1'b0, 4'b0011, 4'h0}) else begin
         errors++;
         $display("ERROR awid/awlen/awsize/awburst/awlock/awcache/awqos = %h/%h/%h/%h/%h/%h/%h",
                  axi_aw.id, axi_aw.len, axi_aw.size, axi_aw.burst, axi_aw.lock,
                  axi_aw.cache, axi_aw.qos);
         $display("ERROR expected 1/00/3/0/0/3/0");
      end
   endtask

   task automatic compare_memory();
      for (int i = 0; i < 256; i++) begin
         assert (u_mem.mem[i] === ref_mem[i]) else begin
            errors++;
            $display("ERROR mem[%h] = %h, expected %h", i[7:0], u_mem.mem[i], ref_mem[i]);
         end
      end
   endtask

   task automatic compare_aw_order();
      assert (u_mem.aw_count - aw_base == exp_aw.size()) else begin
         errors++;
         $display("ERROR aw_count = %h, expected %h", u_mem.aw_count - aw_base, exp_aw.size());
      end
      foreach (exp_aw[i]) begin
         assert (u_mem.aw_log[aw_base + i] === exp_aw[i]) else begin
            errors++;
            $display("ERROR awaddr = %h, expected %h", u_mem.aw_log[aw_base + i], exp_aw[i]);
         end
      end
   endtask

   task automatic start_test();
      exp_aw.delete();
      aw_base = u_mem.aw_count;
   endtask

   task automatic test_reset_state();
      assert (ready_o === 1'b1) else begin
         errors++;
         $display("ERROR ready_o = %h, expected 1", ready_o);
      end
      assert ({awvalid, wvalid, bready} === 3'b000) else begin
         errors++;
         $display("ERROR awvalid/wvalid/bready = %h, expected 0", {awvalid, wvalid, bready});
      end
   endtask

   task automatic test_lane_placement();
      start_test();
      send_write(32'h10, next_rand(), 4'hF);     // lower lane
      check_aw_fields();
      send_write(32'h1C, next_rand(), 4'hF);     // upper lane
      wait_drained();
      compare_aw_order();
      compare_memory();
   endtask

   task automatic test_partial_strobes();
      logic [31:0] data;
      logic [3:0]  strbs [3];
      strbs = '{4'b0010, 4'b1100, 4'b0001};
      start_test();
      for (int i = 0; i < 3; i++) begin
         data = next_rand();
         send_write(32'h24 + 32'(i * 4), data, strbs[i]);
         wait_drained();
         assert (u_mem.w_last_data === {data, data}) else begin
            errors++;
            $display("ERROR wdata = %h, expected %h", u_mem.w_last_data, {data, data});
         end
      end
      compare_memory();
   endtask

   task automatic test_stalled_stream();
      logic [31:0] addr;
      logic [31:0] strb;
      start_test();
      stall_mode = 1;
      for (int i = 0; i < 20; i++) begin
         addr = next_rand() & 32'hFC;
         strb = next_rand();
         send_write(addr, next_rand(), strb[3:0]);
      end
      wait_drained();
      stall_mode = 0;
      compare_aw_order();
      compare_memory();
   endtask

   task automatic test_error_retry();
      start_test();
      err_at = u_mem.b_count + 3;                // third response of this test
      for (int i = 0; i < 4; i++) begin
         send_write(32'h80 + 32'(i * 8), next_rand(), 4'hF);
      end
      wait_drained();
      err_at = 0;
      assert (u_mem.aw_count - aw_base == 5) else begin
         errors++;
         $display("ERROR aw_count = %h, expected %h", u_mem.aw_count - aw_base, 5);
      end
      compare_memory();
   endtask

   task automatic test_full_buffer();
      int n;
      n = 0;
      start_test();
      stall_mode = 2;
      while (ready_o && n < 16) begin
         send_write(32'hC0 + 32'(n * 4), next_rand(), 4'hF);
         n++;
      end
      assert (!ready_o) else begin
         errors++;
         $display("ready_o never fell while the slave was stalled");
      end
      stall_mode = 0;
      wait_drained();
      compare_aw_order();
      compare_memory();
   endtask

   initial begin
      reset_i    = 1'b1;
      valid_i    = 1'b0;
      req_i      = '0;
      err_at     = 0;
      stall_mode = 0;
      rng_state  = SEED;
      sent       = 0;
      errors     = 0;
      aw_base    = 0;
      for (int i = 0; i < 256; i++) begin
         ref_mem[i] = 8'h00;
      end
      repeat (8) @(posedge clk_i);
      #1;
      reset_i = 1'b0;
      test_reset_state();
      test_lane_placement();
      test_partial_strobes();
      test_stalled_stream();
      test_error_retry();
      test_full_buffer();
      $display("writes sent: %0d, errors: %0d", sent, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
hdl/cache_wt_pkg.sv
hdl/axi_wr_pkg.sv
hdl/wt_write_buffer.sv
hdl/wt_lane_align.sv
hdl/axi_write_channel.sv
hdl/cache_write_path.sv
sim/axi_mem_model.sv
sim/cache_write_path_properties.sv
sim/tb_cache_write_path.sv
